//--- compile.f
+incdir+.
isaPkg.sv
uopPkg.sv
elementCounter.sv
uopSequencer.sv
storeDecoder.sv
decodeStage.sv
decodeStageTb.sv

//--- Bender.yml
package:
  name: decode_stage

sources:
  - include_dirs:
      - .
    files:
      - isaPkg.sv
      - uopPkg.sv
      - elementCounter.sv
      - uopSequencer.sv
      - storeDecoder.sv
      - decodeStage.sv
  - target: test
    include_dirs:
      - .
    files:
      - decodeStageTb.sv

//--- decodeStageTb.sv
// Directed testbench for the decode stage.
// Each test task drives instructions into the DUT. A negedge monitor compares
// every cycle of the micro-op stream and busy against a model of the rules.
// Run with decodeStageTb as top.

`timescale 1ns/1ps
`include "uopConsts.svh"

module decodeStageTb;
	import isaPkg::*;
	import uopPkg::*;

	localparam int ClkPeriod = 10;
	localparam int TestCount = 6;
	// Longest test is the random stream with every instruction a vector in the worst case
	localparam int LongestTestCycles = 200 * `VEC_ELEMS + 50;
	localparam int TimeoutCycles = 16 + TestCount * LongestTestCycles;

	logic clk;
	logic reset;
	logic instrValid;
	instr_t instr;
	logic busy;
	logic uopValid;
	microOp_t uop;
	storeFlags_t flags;

	// Model state shared by the monitor and the tests
	microOp_t expQ[$];
	string testName;
	bit monitorOn;
	int uopsSeen;

	decodeStage u_dut
	(
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.busy(busy),
		.uopValid(uopValid),
		.uop(uop),
		.flags(flags)
	);

	always #(ClkPeriod / 2) clk = ~clk;

	// ========================================================================
	// Reporting and compare tasks
	// ========================================================================

	task automatic failRun(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic checkUop(input microOp_t expected, input microOp_t actual);
		if (actual !== expected)
			failRun($sformatf("CHECK FAILED [%s] uop expected %h actual %h",
				testName, expected, actual));
	endtask

	task automatic checkFlags(input storeFlags_t expected, input storeFlags_t actual);
		if (actual !== expected)
			failRun($sformatf("CHECK FAILED [%s] flags expected %b actual %b",
				testName, expected, actual));
	endtask

	// ========================================================================
	// Reference model
	// ========================================================================

	// Register form words are ADD, STVX and LDV and all others use the immediate form
	function automatic bit readsRegForm(input opcode_t op);
		case (op)
			OP_ADD, OP_STVX, OP_LDV: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic int elementCount(input opcode_t op);
		case (op)
			OP_LDV, OP_STV, OP_STVX: return `VEC_ELEMS;
			default: return 1;
		endcase
	endfunction

	// Store classification straight from the opcode table
	function automatic storeFlags_t modelFlags(input opcode_t op);
		storeFlags_t f;
		f.store = 1'b0;
		f.vstore = 1'b0;
		f.vstoreNdx = 1'b0;
		f.size = SZ_NONE;
		case (op)
			OP_STB:
			begin
				f.store = 1'b1;
				f.size = SZ_BYTE;
			end
			OP_STW, OP_STI:
			begin
				f.store = 1'b1;
				f.size = SZ_WORD;
			end
			OP_STV, OP_STVX:
			begin
				f.vstore = 1'b1;
				f.vstoreNdx = (op == OP_STVX);
				f.size = SZ_WORD;
			end
			default: f.size = SZ_NONE;
		endcase
		return f;
	endfunction

	// Queue every micro-op an accepted instruction should produce, in order
	function automatic void expandInstr(input instr_t w);
		microOp_t u;
		int n;
		u.opcode = w.iForm.opcode;
		u.rd = w.iForm.rd;
		u.ra = w.iForm.ra;
		u.rb = readsRegForm(u.opcode) ? w.rForm.rb : '0;
		u.imm = readsRegForm(u.opcode) ? '0 : w.iForm.imm;
		n = elementCount(u.opcode);
		for (int i = 0; i < n; i++)
		begin
			u.elemIdx = `ELEM_IDX_W'(i);
			u.lastElem = (i == n - 1);
			expQ.push_back(u);
		end
	endfunction

	// One model step per cycle checks what is shown now and then notes a new accept
	always @(negedge clk)
	begin
		microOp_t expUop;
		logic modelBusy;
		if (monitorOn)
		begin
			// Pulses are counted as the DUT shows them, apart from the model queue
			if (uopValid === 1'b1)
				uopsSeen++;
			if (expQ.size() == 0)
			begin
				if (uopValid !== 1'b0)
					failRun("A micro-op appeared with no instruction outstanding");
			end
			else
			begin
				expUop = expQ.pop_front();
				if (uopValid !== 1'b1)
					failRun($sformatf("Micro-op missing in test %s", testName));
				checkUop(expUop, uop);
				checkFlags(modelFlags(expUop.opcode), flags);
			end
			// Still owing elements means the sequencer is expanding
			modelBusy = (expQ.size() != 0);
			if (busy !== modelBusy)
				failRun($sformatf("CHECK FAILED [%s] busy expected %b actual %b",
					testName, modelBusy, busy));
			if (instrValid && !modelBusy)
				expandInstr(instr);
		end
	end

	// ========================================================================
	// Stimulus helpers
	// ========================================================================

	function automatic instr_t makeImm(input opcode_t op, input logic [4:0] rd,
		input logic [4:0] ra, input logic [15:0] imm);
		instr_t w;
		w.iForm.opcode = op;
		w.iForm.rd = rd;
		w.iForm.ra = ra;
		w.iForm.imm = imm;
		return w;
	endfunction

	function automatic instr_t makeReg(input opcode_t op, input logic [4:0] rd,
		input logic [4:0] ra, input logic [4:0] rb, input logic [10:0] func);
		instr_t w;
		w.rForm.opcode = op;
		w.rForm.rd = rd;
		w.rForm.ra = ra;
		w.rForm.rb = rb;
		w.rForm.func = func;
		return w;
	endfunction

	// Called 1 ns after an edge. Holds the word until an edge with busy low
	// and returns 1 ns after that edge with the number of busy cycles waited
	task automatic sendInstr(input instr_t w, output int waits);
		instrValid = 1'b1;
		instr = w;
		waits = 0;
		@(negedge clk);
		while (busy)
		begin
			waits++;
			@(negedge clk);
		end
		@(posedge clk);
		#1;
	endtask

	// Let the stream finish and add one cycle that must show the DUT idle
	task automatic drain();
		instrValid = 1'b0;
		while (expQ.size() != 0)
		begin
			@(posedge clk);
			#1;
		end
		@(posedge clk);
		#1;
	endtask

	// ========================================================================
	// Tests
	// ========================================================================

	task automatic resetState();
		testName = "resetState";
		@(negedge clk);
		if (busy !== 1'b0 || uopValid !== 1'b0)
			failRun($sformatf("CHECK FAILED [%s] busy/uopValid expected 00 actual %b%b",
				testName, busy, uopValid));
		@(posedge clk);
		#1;
	endtask

	task automatic scalarStores();
		int waits;
		testName = "scalarStores";
		sendInstr(makeImm(OP_STB, 5'd3, 5'd7, 16'hbeef), waits);
		sendInstr(makeImm(OP_STW, 5'd31, 5'd0, 16'h1234), waits);
		sendInstr(makeImm(OP_STI, 5'd12, 5'd21, 16'hffff), waits);
		drain();
	endtask

	task automatic aluOps();
		int waits;
		testName = "aluOps";
		// The func bits are noise here and must not leak into imm
		sendInstr(makeReg(OP_ADD, 5'd1, 5'd2, 5'd3, 11'h5a5), waits);
		sendInstr(makeImm(OP_ADDI, 5'd4, 5'd5, 16'h8001), waits);
		drain();
	endtask

	task automatic vectorOps();
		int waits;
		testName = "vectorOps";
		sendInstr(makeImm(OP_STV, 5'd8, 5'd9, 16'h0100), waits);
		drain();
		sendInstr(makeReg(OP_STVX, 5'd10, 5'd11, 5'd12, 11'h7ff), waits);
		drain();
		sendInstr(makeReg(OP_LDV, 5'd13, 5'd14, 5'd15, 11'h001), waits);
		drain();
	endtask

	task automatic heldWhileBusy();
		int waits;
		testName = "heldWhileBusy";
		sendInstr(makeImm(OP_STV, 5'd4, 5'd5, 16'h0040), waits);
		// Presented at once so it sits through the whole expansion
		sendInstr(makeImm(OP_STB, 5'd6, 5'd7, 16'h0001), waits);
		if (waits != `VEC_ELEMS - 1)
			failRun($sformatf("CHECK FAILED [%s] busy cycles expected %0d actual %0d",
				testName, `VEC_ELEMS - 1, waits));
		sendInstr(makeReg(OP_ADD, 5'd1, 5'd1, 5'd1, 11'h0), waits);
		if (waits != 0)
			failRun($sformatf("CHECK FAILED [%s] busy cycles expected 0 actual %0d",
				testName, waits));
		drain();
	endtask

	task automatic randomStream();
		opcode_t opList[11] = '{OP_NOP, OP_ADD, OP_ADDI, OP_LDB, OP_LDW, OP_LDV,
			OP_STB, OP_STW, OP_STI, OP_STV, OP_STVX};
		instr_t w;
		int waits;
		int expectCount;
		int startSeen;
		testName = "randomStream";
		expectCount = 0;
		startSeen = uopsSeen;
		for (int i = 0; i < 200; i++)
		begin
			w = $urandom;
			w.rForm.opcode = opList[$urandom % 11];
			expectCount += elementCount(w.rForm.opcode);
			sendInstr(w, waits);
			// Idle gaps now and then between instructions
			if ($urandom % 4 == 0)
			begin
				instrValid = 1'b0;
				@(posedge clk);
				#1;
			end
		end
		drain();
		if (uopsSeen - startSeen != expectCount)
			failRun($sformatf("CHECK FAILED [%s] micro-op count expected %0d actual %0d",
				testName, expectCount, uopsSeen - startSeen));
	endtask

	// ========================================================================
	// Run control
	// ========================================================================

	initial
	begin
		#(TimeoutCycles * ClkPeriod);
		failRun("Timeout: the decode stage stopped producing micro-ops");
	end

	initial
	begin
		void'($urandom(32'hebfa));
		clk = 1'b0;
		reset = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		testName = "reset";
		monitorOn = 1'b0;
		uopsSeen = 0;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;
		monitorOn = 1'b1;
		resetState();
		scalarStores();
		aluOps();
		vectorOps();
		heldWhileBusy();
		randomStream();
		$display("sim passed");
		$finish;
	end

endmodule

//--- decodeStage.sv
// Top level of the store-classification decode stage.
// Instructions come in on instrValid/instr and leave as a stream of
// micro-ops with their store flags; busy holds upstream during expansion.

`timescale 1ns/1ps
`include "uopConsts.svh"

module decodeStage
(
	input logic clk,
	input logic reset,
	input logic instrValid,
	input isaPkg::instr_t instr,
	output logic busy,
	output logic uopValid,
	output uopPkg::microOp_t uop,
	output uopPkg::storeFlags_t flags
);

	// Sequencer to counter controls and counter status back
	logic load;
	logic step;
	logic [`ELEM_IDX_W-1:0] elemIdx;
	logic last;

	uopSequencer u_sequencer
	(
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.elemIdx(elemIdx),
		.last(last),
		.load(load),
		.step(step),
		.busy(busy),
		.uopValid(uopValid),
		.uop(uop)
	);

	elementCounter u_counter
	(
		.clk(clk),
		.reset(reset),
		.load(load),
		.step(step),
		.elemIdx(elemIdx),
		.last(last)
	);

	// Classifies the registered micro-op so flags share its cycle
	storeDecoder u_storeDecoder
	(
		.uop(uop),
		.flags(flags)
	);

endmodule

//--- storeDecoder.sv
// Store classifier for issued micro-ops.
// Purely combinational; flags line up with the micro-op in the same cycle
// and mark scalar, vector and indexed vector stores with their size.

`timescale 1ns/1ps

module storeDecoder
(
	input uopPkg::microOp_t uop,
	output uopPkg::storeFlags_t flags
);
	import isaPkg::*;
	import uopPkg::*;

	// Scalar stores of any size
	function automatic logic isStore(input opcode_t op);
		case (op)
			OP_STB, OP_STW, OP_STI: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// Vector stores, both strided and indexed
	function automatic logic isVecStore(input opcode_t op);
		return (op == OP_STV) || (op == OP_STVX);
	endfunction

	// Indexed vector store only
	function automatic logic isVecStoreNdx(input opcode_t op);
		return op == OP_STVX;
	endfunction

	// Byte stores are the one narrow case, every other store writes a word
	function automatic storeSize_t sizeOf(input opcode_t op);
		case (op)
			OP_STB: return SZ_BYTE;
			OP_STW, OP_STI, OP_STV, OP_STVX: return SZ_WORD;
			default: return SZ_NONE;
		endcase
	endfunction

	assign flags.store = isStore(uop.opcode);
	assign flags.vstore = isVecStore(uop.opcode);
	assign flags.vstoreNdx = isVecStoreNdx(uop.opcode);
	assign flags.size = sizeOf(uop.opcode);

endmodule

//--- uopSequencer.sv
// Micro-op sequencer for the decode stage.
// Accepts one instruction when idle, issues element 0 the next cycle and
// for vector opcodes keeps issuing one element per cycle from a saved copy.
// busy tells upstream to hold its instruction until expansion ends.

`timescale 1ns/1ps
`include "uopConsts.svh"

module uopSequencer
(
	input logic clk,
	input logic reset,
	input logic instrValid,
	input isaPkg::instr_t instr,
	input logic [`ELEM_IDX_W-1:0] elemIdx,
	input logic last,
	output logic load,
	output logic step,
	output logic busy,
	output logic uopValid,
	output uopPkg::microOp_t uop
);
	import isaPkg::*;
	import uopPkg::*;

	typedef enum logic {Idle, Expand} seqState_t;

	seqState_t state;
	instr_t savedInstr;
	logic accept;
	logic acceptVec;

	// Turn an instruction word into a micro-op for one element
	// Only the field that belongs to the form is copied, the other is zeroed
	function automatic microOp_t buildUop
	(
		input instr_t word,
		input logic [`ELEM_IDX_W-1:0] idx,
		input logic lastOne
	);
		microOp_t op;
		// Opcode, rd and ra sit at the same bits in both views
		op.opcode = word.rForm.opcode;
		op.rd = word.rForm.rd;
		op.ra = word.rForm.ra;
		if (isRegForm(word.rForm.opcode))
		begin
			op.rb = word.rForm.rb;
			op.imm = '0;
		end
		else
		begin
			op.rb = '0;
			op.imm = word.iForm.imm;
		end
		op.elemIdx = idx;
		op.lastElem = lastOne;
		return op;
	endfunction

	// ========================================================================
	// Control
	// ========================================================================

	// A new instruction is only taken while idle
	assign accept = instrValid && (state == Idle);
	assign acceptVec = accept && isVector(instr.rForm.opcode);

	// Counter starts on a vector accept and advances with every expanded element
	assign load = acceptVec;
	assign step = (state == Expand);

	// Busy covers the cycles in which expansion still owes elements
	assign busy = (state == Expand);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= Idle;
			uopValid <= 1'b0;
		end
		else
		begin
			uopValid <= 1'b0;
			case (state)
				Idle:
				begin
					if (accept)
						uopValid <= 1'b1;
					if (acceptVec)
						state <= Expand;
				end
				Expand:
				begin
					uopValid <= 1'b1;
					// Leave after queuing the last element so the next accept lines up
					if (last)
						state <= Idle;
				end
				default:
					state <= Idle;
			endcase
		end
	end

	// ========================================================================
	// Micro-op payload
	// ========================================================================

	// Element 0 is built straight from the input, later ones from the copy
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			savedInstr <= instr;
			uop <= buildUop(instr, '0, !isVector(instr.rForm.opcode));
		end
		else if (state == Expand)
			uop <= buildUop(savedInstr, elemIdx, last);
	end

endmodule

//--- elementCounter.sv
// Element counter for vector expansion.
// The sequencer loads it when a vector instruction is accepted and steps
// it once per issued element; last marks the final element.

`timescale 1ns/1ps
`include "uopConsts.svh"

module elementCounter
(
	input logic clk,
	input logic reset,
	input logic load,
	input logic step,
	output logic [`ELEM_IDX_W-1:0] elemIdx,
	output logic last
);

	// Element 0 leaves with the accept, so the count restarts at 1
	always_ff @(posedge clk)
	begin
		if (reset)
			elemIdx <= '0;
		else if (load)
			elemIdx <= `ELEM_IDX_W'(1);
		else if (step)
			elemIdx <= elemIdx + `ELEM_IDX_W'(1);
	end

	// The counter wraps to zero after the final step, which is harmless
	// because the sequencer has gone idle by then
	assign last = (elemIdx == `ELEM_IDX_W'(`VEC_ELEMS - 1));

endmodule

//--- uopPkg.sv
// Micro-op types produced by the decode stage.
// The sequencer emits microOp_t and the store decoder tags each one
// with a storeFlags_t.

`include "uopConsts.svh"

package uopPkg;

	// One micro-op, a whole scalar instruction or one vector element
	typedef struct packed
	{
		isaPkg::opcode_t opcode;
		logic [`REG_W-1:0] rd;
		logic [`REG_W-1:0] ra;
		// Zero when the instruction came in immediate form
		logic [`REG_W-1:0] rb;
		// Zero when the instruction came in register form
		logic [`IMM_W-1:0] imm;
		logic [`ELEM_IDX_W-1:0] elemIdx;
		// Set on a scalar micro-op and on the final vector element
		logic lastElem;
	} microOp_t;

	// Size of the memory write, none for anything that is not a store
	typedef enum logic [1:0] {SZ_NONE, SZ_BYTE, SZ_WORD} storeSize_t;

	// Store classification of one micro-op
	typedef struct packed
	{
		logic store;
		logic vstore;
		logic vstoreNdx;
		storeSize_t size;
	} storeFlags_t;

endpackage

//--- isaPkg.sv
// Instruction encoding for the decode stage.
// Holds the opcode enumeration, the two instruction forms and the union
// that overlays them, plus helpers that tell the forms apart.

`include "uopConsts.svh"

package isaPkg;

	// ========================================================================
	// Opcodes
	// ========================================================================

	// Loads sit in 0x08, stores in 0x10 so the groups read easily in a dump
	typedef enum logic [`OPCODE_W-1:0]
	{
		OP_NOP  = 6'h00,
		OP_ADD  = 6'h01,
		OP_ADDI = 6'h02,
		OP_LDB  = 6'h08,
		OP_LDW  = 6'h09,
		OP_LDV  = 6'h0a,
		OP_STB  = 6'h10,
		OP_STW  = 6'h11,
		OP_STI  = 6'h12,
		OP_STV  = 6'h14,
		OP_STVX = 6'h15
	} opcode_t;

	// ========================================================================
	// Instruction forms
	// ========================================================================

	// Register form with three register fields and a function field
	typedef struct packed
	{
		opcode_t opcode;
		logic [`REG_W-1:0] rd;
		logic [`REG_W-1:0] ra;
		logic [`REG_W-1:0] rb;
		logic [`FUNC_W-1:0] func;
	} regForm_t;

	// Immediate form where rb and func give way to a 16-bit constant
	typedef struct packed
	{
		opcode_t opcode;
		logic [`REG_W-1:0] rd;
		logic [`REG_W-1:0] ra;
		logic [`IMM_W-1:0] imm;
	} immForm_t;

	// The same 32-bit word seen both ways; the opcode picks the view
	typedef union packed
	{
		regForm_t rForm;
		immForm_t iForm;
	} instr_t;

	// Opcodes whose word must be read in register form
	function automatic logic isRegForm(input opcode_t op);
		return (op == OP_ADD) || (op == OP_STVX) || (op == OP_LDV);
	endfunction

	// Opcodes that expand into one micro-op per vector element
	function automatic logic isVector(input opcode_t op);
		return (op == OP_LDV) || (op == OP_STV) || (op == OP_STVX);
	endfunction

endpackage

//--- uopConsts.svh
// Shared sizing constants for the decode stage.
// Include this header wherever vector length or field widths are needed.
// The packages build their types from these values.

`ifndef UOP_CONSTS_SVH
`define UOP_CONSTS_SVH

// Number of elements a vector load or store expands into
`define VEC_ELEMS 4

// Width of the element index carried in each micro-op
`define ELEM_IDX_W 2

// Instruction field widths, the register form spends the rest on func
`define OPCODE_W 6
`define REG_W 5
`define IMM_W 16
`define FUNC_W 11

`endif
